//--- Bender.yml
package:
  name: motor_cmd_seq

dependencies: {}

sources:
  # Packages first, then the design from the bottom up
  - src/motor_axi_pkg.sv
  - src/motor_ctrl_pkg.sv
  - src/motor_sequencer.sv
  - src/axi_single_writer.sv
  - src/dac_spi_responder.sv
  - src/motor_cmd_top.sv

  - target: test
    files:
      - tb/motor_cmd_props.sv
      - tb/tb_motor_cmd_top.sv

//--- flist.f
src/motor_axi_pkg.sv
src/motor_ctrl_pkg.sv
src/motor_sequencer.sv
src/axi_single_writer.sv
src/dac_spi_responder.sv
src/motor_cmd_top.sv
tb/motor_cmd_props.sv
tb/tb_motor_cmd_top.sv

//--- src/axi_single_writer.sv
`timescale 1ns/1ps

module axi_single_writer #(
	parameter int WATCH_DOG_WIDTH = 12
) (
	input  logic                      sys_clk,
	input  logic                      sys_rst,
	input  logic                      write_start,
	input  motor_ctrl_pkg::cmd_t      cmd_value,

	// Write address channel
	output motor_axi_pkg::axi_id_t    awid,
	output motor_axi_pkg::axi_addr_t  awaddr,
	output logic                      awvalid,
	input  logic                      awready,

	// Write data channel
	output motor_axi_pkg::axi_data_t  wdata,
	output motor_axi_pkg::axi_strb_t  wstrb,
	output logic                      wlast,
	output logic                      wvalid,
	input  logic                      wready,

	// Write response channel
	input  motor_axi_pkg::axi_id_t    bid,
	input  logic [1:0]                bresp,
	input  logic                      bvalid,
	output logic                      bready,

	output logic                      write_done,
	output logic                      write_timeout
);

	// One-hot state bit positions
	localparam int ST_IDLE = 0;
	localparam int ST_ADDR = 1;
	localparam int ST_DATA = 2;
	localparam int ST_RESP = 3;
	localparam int ST_TOUT = 4;

	logic [4:0]                 state;
	logic [4:0]                 state_next;
	logic [WATCH_DOG_WIDTH-1:0] wd_cnt;
	logic                       wd_expired;
	logic                       write_launch;
	motor_axi_pkg::axi_data_t   cmd_word;

	// ********************
	// Write FSM
	// ********************

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= 5'b00001;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = '0;
		case (1'b1)
			state[ST_IDLE]: begin
				if (write_start)
					state_next[ST_ADDR] = 1'b1;
				else
					state_next[ST_IDLE] = 1'b1;
			end
			state[ST_ADDR]: begin
				if (awready)
					state_next[ST_DATA] = 1'b1;
				else if (wd_expired)
					state_next[ST_TOUT] = 1'b1;
				else
					state_next[ST_ADDR] = 1'b1;
			end
			state[ST_DATA]: begin
				if (wready)
					state_next[ST_RESP] = 1'b1;
				else if (wd_expired)
					state_next[ST_TOUT] = 1'b1;
				else
					state_next[ST_DATA] = 1'b1;
			end
			state[ST_RESP]: begin
				if (bvalid)
					state_next[ST_IDLE] = 1'b1;
				else if (wd_expired)
					state_next[ST_TOUT] = 1'b1;
				else
					state_next[ST_RESP] = 1'b1;
			end
			state[ST_TOUT]: begin
				state_next[ST_IDLE] = 1'b1;
			end
			default: state_next[ST_IDLE] = 1'b1;
		endcase
	end

	// Watchdog, restarts whenever the state moves
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wd_cnt <= '0;
		end else if (state != state_next) begin
			wd_cnt <= '0;
		end else begin
			wd_cnt <= wd_cnt + 1'b1;
		end
	end

	// Last cycle of a full 2^WATCH_DOG_WIDTH phase
	assign wd_expired = &wd_cnt;

	assign write_launch = state[ST_IDLE] && write_start;

	// ********************
	// Channel payloads
	// ********************

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			awid <= '0;
		end else if (write_launch) begin
			awid <= awid + 1'b1;
		end
	end

	// Word frozen at launch, held through the data phase
	always_ff @(posedge sys_clk) begin
		if (write_launch) begin
			cmd_word <= {motor_ctrl_pkg::MOTOR_ENABLE_CODE,
				motor_ctrl_pkg::MOTOR_FORWARD_CODE,
				{(16 - motor_ctrl_pkg::CMD_WIDTH){1'b0}}, cmd_value,
				16'h0000};
		end
	end

	assign awaddr  = motor_axi_pkg::AXI_ADDR_ETH2MOTOR;
	assign awvalid = state[ST_ADDR];

	assign wvalid = state[ST_DATA];
	// Every write is a single beat
	assign wlast  = state[ST_DATA];
	assign wdata  = state[ST_DATA] ? cmd_word : '0;
	assign wstrb  = {motor_axi_pkg::AXI_STRB_WIDTH{state[ST_DATA]}};

	// Response ID and code are taken as they come
	assign bready     = state[ST_RESP];
	assign write_done = state[ST_RESP] && bvalid;

	assign write_timeout = state[ST_TOUT];

endmodule

//--- src/dac_spi_responder.sv
`timescale 1ns/1ps

module dac_spi_responder (
	input  logic                 sys_clk,
	input  logic                 sys_rst,
	input  logic                 sclk,
	input  logic                 sync_n,
	input  logic                 sdin,
	input  motor_ctrl_pkg::cmd_t cmd_value,
	output logic                 sdo
);

	localparam int FRAME_BITS = motor_ctrl_pkg::DAC_FRAME_BITS;
	localparam int CNT_WIDTH  = $clog2(FRAME_BITS + 1);

	logic                       sclk_d;
	logic                       sync_d;
	logic                       sclk_fall;
	logic                       sync_fall;
	logic                       bit_take;
	logic [CNT_WIDTH-1:0]       bit_cnt;
	logic                       read_pend;
	logic                       read_active;
	motor_ctrl_pkg::dac_frame_t rx_shift;
	motor_ctrl_pkg::dac_frame_t rx_next;
	motor_ctrl_pkg::dac_frame_t tx_shift;

	// ********************
	// Edge detection
	// ********************

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			sclk_d <= 1'b0;
			sync_d <= 1'b1;
		end else begin
			sclk_d <= sclk;
			sync_d <= sync_n;
		end
	end

	assign sclk_fall = sclk_d && !sclk;
	assign sync_fall = sync_d && !sync_n;

	// Falling sclk inside a frame, extra clocks past 24 bits are ignored
	assign bit_take = !sync_n && sclk_fall && (bit_cnt < CNT_WIDTH'(FRAME_BITS));

	assign rx_next = {rx_shift[FRAME_BITS-2:0], sdin};

	// ********************
	// Frame control
	// ********************

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			bit_cnt     <= '0;
			read_pend   <= 1'b0;
			read_active <= 1'b0;
		end else if (sync_n) begin
			bit_cnt     <= '0;
			read_active <= 1'b0;
		end else if (sync_fall) begin
			// Read command seen in the previous frame
			read_active <= read_pend;
		end else if (bit_take) begin
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == CNT_WIDTH'(FRAME_BITS - 1)) begin
				read_pend   <= (rx_next == motor_ctrl_pkg::DAC_READ_FRAME);
				read_active <= 1'b0;
			end
		end
	end

	// MSB first capture
	always_ff @(posedge sys_clk) begin
		if (bit_take) begin
			rx_shift <= rx_next;
		end
	end

	// Readback loaded as sync_n falls, one bit per falling sclk
	always_ff @(posedge sys_clk) begin
		if (sync_fall) begin
			tx_shift <= {8'h00, motor_ctrl_pkg::DAC_READBACK_TAG, cmd_value, 2'b00};
		end else if (bit_take) begin
			tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};
		end
	end

	assign sdo = read_active && tx_shift[FRAME_BITS-1];

endmodule

//--- src/motor_axi_pkg.sv
package motor_axi_pkg;

	// ********************
	// Bus widths
	// ********************

	localparam int AXI_ID_WIDTH   = 4;
	localparam int AXI_ADDR_WIDTH = 16;
	localparam int AXI_DATA_WIDTH = 64;
	localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

	typedef logic [AXI_ID_WIDTH-1:0]   axi_id_t;
	typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
	typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;
	typedef logic [AXI_STRB_WIDTH-1:0] axi_strb_t;

	// ********************
	// Fixed burst fields
	// ********************

	// Eight bytes per beat
	localparam logic [2:0] AXI_SIZE = 3'd3;

	// Single beat, awlen counts beats minus one
	localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;

	// INCR burst type
	localparam logic [1:0] AXI_BURST_INCR = 2'd1;

	// ********************
	// Address map
	// ********************

	// Motor command register, low half of the system address
	localparam axi_addr_t AXI_ADDR_ETH2MOTOR = 16'h0000;

endpackage

//--- src/motor_cmd_top.sv
`timescale 1ns/1ps

module motor_cmd_top #(
	parameter int WATCH_DOG_WIDTH = 12
) (
	input  logic                     sys_clk,
	input  logic                     sys_rst,

	// Motor alarm
	input  logic                     alarm_reset,
	output logic                     alarm_out_n,

	// AXI write address channel
	output motor_axi_pkg::axi_id_t   awid,
	output motor_axi_pkg::axi_addr_t awaddr,
	output logic [7:0]               awlen,
	output logic [2:0]               awsize,
	output logic [1:0]               awburst,
	output logic                     awvalid,
	input  logic                     awready,

	// AXI write data channel
	output motor_axi_pkg::axi_data_t wdata,
	output motor_axi_pkg::axi_strb_t wstrb,
	output logic                     wlast,
	output logic                     wvalid,
	input  logic                     wready,

	// AXI write response channel
	input  motor_axi_pkg::axi_id_t   bid,
	input  logic [1:0]               bresp,
	input  logic                     bvalid,
	output logic                     bready,

	output logic                     wr_timeout,

	// Serial DAC port
	input  logic                     sclk,
	input  logic                     sync_n,
	input  logic                     sdin,
	output logic                     sdo
);

	logic                 write_start;
	logic                 write_done;
	motor_ctrl_pkg::cmd_t cmd_value;

	// Fixed single-beat INCR write
	assign awlen   = motor_axi_pkg::AXI_LEN_SINGLE;
	assign awsize  = motor_axi_pkg::AXI_SIZE;
	assign awburst = motor_axi_pkg::AXI_BURST_INCR;

	motor_sequencer u_sequencer (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.alarm_reset (alarm_reset),
		.write_done  (write_done),
		.write_start (write_start),
		.alarm_out_n (alarm_out_n),
		.cmd_value   (cmd_value)
	);

	axi_single_writer #(
		.WATCH_DOG_WIDTH (WATCH_DOG_WIDTH)
	) u_writer (
		.sys_clk       (sys_clk),
		.sys_rst       (sys_rst),
		.write_start   (write_start),
		.cmd_value     (cmd_value),
		.awid          (awid),
		.awaddr        (awaddr),
		.awvalid       (awvalid),
		.awready       (awready),
		.wdata         (wdata),
		.wstrb         (wstrb),
		.wlast         (wlast),
		.wvalid        (wvalid),
		.wready        (wready),
		.bid           (bid),
		.bresp         (bresp),
		.bvalid        (bvalid),
		.bready        (bready),
		.write_done    (write_done),
		.write_timeout (wr_timeout)
	);

	dac_spi_responder u_dac (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.sclk      (sclk),
		.sync_n    (sync_n),
		.sdin      (sdin),
		.cmd_value (cmd_value),
		.sdo       (sdo)
	);

endmodule

//--- src/motor_ctrl_pkg.sv
package motor_ctrl_pkg;

	// ********************
	// Cycle timer
	// ********************

	localparam int TIMER_WIDTH = 12;

	typedef logic [TIMER_WIDTH-1:0] timer_t;

	// Write trigger point within the period
	localparam timer_t TRIG_COUNT = 12'h050;

	// Alarm window, both ends inclusive
	localparam timer_t ALARM_START  = 12'h650;
	localparam timer_t ALARM_END    = 12'hF70;
	// First value past the window
	localparam timer_t ALARM_RESUME = 12'hF71;

	// ********************
	// Motor command word
	// ********************

	localparam int CMD_WIDTH = 10;

	typedef logic [CMD_WIDTH-1:0] cmd_t;

	localparam cmd_t CMD_INIT = 10'd8;

	localparam logic [15:0] MOTOR_ENABLE_CODE  = 16'hEAEA;
	localparam logic [15:0] MOTOR_FORWARD_CODE = 16'h1EAF;

	// ********************
	// Serial DAC frames
	// ********************

	localparam int DAC_FRAME_BITS = 24;

	typedef logic [DAC_FRAME_BITS-1:0] dac_frame_t;

	// Read command, the frame after it is a readback
	localparam dac_frame_t DAC_READ_FRAME = 24'h910000;

	localparam logic [3:0] DAC_READBACK_TAG = 4'h9;

endpackage

//--- src/motor_sequencer.sv
`timescale 1ns/1ps

module motor_sequencer (
	input  logic                 sys_clk,
	input  logic                 sys_rst,
	input  logic                 alarm_reset,
	input  logic                 write_done,
	output logic                 write_start,
	output logic                 alarm_out_n,
	output motor_ctrl_pkg::cmd_t cmd_value
);

	motor_ctrl_pkg::timer_t timer;
	logic                   in_alarm_window;

	// ********************
	// Period timer
	// ********************

	// Free running, alarm_reset jumps past the alarm window
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			timer <= '0;
		end else if (alarm_reset) begin
			timer <= motor_ctrl_pkg::ALARM_RESUME;
		end else begin
			timer <= timer + 1'b1;
		end
	end

	assign in_alarm_window = (timer >= motor_ctrl_pkg::ALARM_START) &&
		(timer <= motor_ctrl_pkg::ALARM_END);

	// ********************
	// Trigger and alarm
	// ********************

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			write_start <= 1'b0;
			alarm_out_n <= 1'b1;
		end else begin
			write_start <= (timer == motor_ctrl_pkg::TRIG_COUNT);
			// Active low, released at once by alarm_reset
			alarm_out_n <= !in_alarm_window || alarm_reset;
		end
	end

	// Command value steps once per completed write
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cmd_value <= motor_ctrl_pkg::CMD_INIT;
		end else if (write_done) begin
			cmd_value <= cmd_value + 1'b1;
		end
	end

endmodule

//--- tb/motor_cmd_props.sv
`timescale 1ns/1ps

module motor_cmd_props (
	input logic                     sys_clk,
	input logic                     sys_rst,
	input motor_axi_pkg::axi_id_t   awid,
	input motor_axi_pkg::axi_addr_t awaddr,
	input logic                     awvalid,
	input logic                     awready,
	input motor_axi_pkg::axi_data_t wdata,
	input motor_axi_pkg::axi_strb_t wstrb,
	input logic                     wlast,
	input logic                     wvalid,
	input logic                     wready,
	input logic                     bvalid,
	input logic                     bready,
	input logic                     wr_timeout
);

	int assert_errors = 0;

	// ********************
	// Channel stability
	// ********************

	// A watchdog abort is the only way out without a handshake
	aw_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		awvalid && !awready |=> (awvalid && $stable(awid) && $stable(awaddr)) || wr_timeout)
		else begin
			assert_errors++;
			$error("awvalid or its payload changed before awready");
		end

	w_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		wvalid && !wready |=> (wvalid && $stable(wdata) && $stable(wstrb)) || wr_timeout)
		else begin
			assert_errors++;
			$error("wvalid or its payload changed before wready");
		end

	b_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		bready && !bvalid |=> bready || wr_timeout)
		else begin
			assert_errors++;
			$error("bready dropped before bvalid");
		end

	// Single beat writes
	wlast_match: assert property (@(posedge sys_clk) disable iff (sys_rst)
		wlast == wvalid)
		else begin
			assert_errors++;
			$error("wlast differs from wvalid");
		end

	timeout_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst)
		wr_timeout |=> !wr_timeout)
		else begin
			assert_errors++;
			$error("wr_timeout stayed high for two cycles");
		end

endmodule

//--- tb/tb_motor_cmd_top.sv
`timescale 1ns/1ps

module tb_motor_cmd_top;

	localparam int WD_WIDTH      = 6;
	localparam int PERIOD_CYCLES = 4096;
	localparam int AW_WAIT_LIMIT = 5000;
	localparam int PHASE_LIMIT   = 100;
	localparam int FRAME_BITS    = motor_ctrl_pkg::DAC_FRAME_BITS;

	// Signal selectors for wait_for
	localparam int SIG_AWVALID = 0;
	localparam int SIG_WVALID  = 1;
	localparam int SIG_BREADY  = 2;
	localparam int SIG_TIMEOUT = 3;
	localparam int SIG_ALARM_N = 4;

	logic                     sys_clk;
	logic                     sys_rst;
	logic                     alarm_reset;
	logic                     alarm_out_n;
	motor_axi_pkg::axi_id_t   awid;
	motor_axi_pkg::axi_addr_t awaddr;
	logic [7:0]               awlen;
	logic [2:0]               awsize;
	logic [1:0]               awburst;
	logic                     awvalid;
	logic                     awready;
	motor_axi_pkg::axi_data_t wdata;
	motor_axi_pkg::axi_strb_t wstrb;
	logic                     wlast;
	logic                     wvalid;
	logic                     wready;
	motor_axi_pkg::axi_id_t   bid;
	logic [1:0]               bresp;
	logic                     bvalid;
	logic                     bready;
	logic                     wr_timeout;
	logic                     sclk;
	logic                     sync_n;
	logic                     sdin;
	logic                     sdo;

	int                       cycle;
	int                       errors;
	bit                       timed_out;
	string                    test_name;
	motor_ctrl_pkg::cmd_t     exp_cmd;
	motor_axi_pkg::axi_id_t   exp_id;

	motor_cmd_top #(
		.WATCH_DOG_WIDTH (WD_WIDTH)
	) DUT (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.alarm_reset (alarm_reset),
		.alarm_out_n (alarm_out_n),
		.awid        (awid),
		.awaddr      (awaddr),
		.awlen       (awlen),
		.awsize      (awsize),
		.awburst     (awburst),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wlast       (wlast),
		.wvalid      (wvalid),
		.wready      (wready),
		.bid         (bid),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.wr_timeout  (wr_timeout),
		.sclk        (sclk),
		.sync_n      (sync_n),
		.sdin        (sdin),
		.sdo         (sdo)
	);

	bind motor_cmd_top motor_cmd_props u_props (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.awid       (awid),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wlast      (wlast),
		.wvalid     (wvalid),
		.wready     (wready),
		.bvalid     (bvalid),
		.bready     (bready),
		.wr_timeout (wr_timeout)
	);

	initial sys_clk = 1'b0;
	always #2 sys_clk = ~sys_clk;

	initial cycle = 0;
	always @(posedge sys_clk) cycle <= cycle + 1;

	// ********************
	// Expected values
	// ********************

	function automatic motor_axi_pkg::axi_data_t motor_word(input motor_ctrl_pkg::cmd_t value);
		return {motor_ctrl_pkg::MOTOR_ENABLE_CODE, motor_ctrl_pkg::MOTOR_FORWARD_CODE,
			6'b000000, value, 16'h0000};
	endfunction

	function automatic motor_ctrl_pkg::dac_frame_t readback_frame(
			input motor_ctrl_pkg::cmd_t value);
		return {8'h00, motor_ctrl_pkg::DAC_READBACK_TAG, value, 2'b00};
	endfunction

	function automatic int ready_delay();
		return $urandom_range(5, 0);
	endfunction

	// ********************
	// Compare tasks
	// ********************

	task automatic check_id(input string what, input motor_axi_pkg::axi_id_t expected,
			input motor_axi_pkg::axi_id_t actual);
		if (actual !== expected) begin
			errors++;
			$display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_addr(input string what, input motor_axi_pkg::axi_addr_t expected,
			input motor_axi_pkg::axi_addr_t actual);
		if (actual !== expected) begin
			errors++;
			$display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_burst(input string what, input logic [7:0] expected,
			input logic [7:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_data(input string what, input motor_axi_pkg::axi_data_t expected,
			input motor_axi_pkg::axi_data_t actual);
		if (actual !== expected) begin
			errors++;
			$display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_cmd(input string what, input motor_ctrl_pkg::dac_frame_t expected,
			input motor_ctrl_pkg::dac_frame_t actual);
		if (actual !== expected) begin
			errors++;
			$display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			errors++;
			$display("error %s %s: expected %b, actual %b", test_name, what, expected, actual);
		end
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		if (actual != expected) begin
			errors++;
			$display("error %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
		end
	endtask

	// ********************
	// Bus models
	// ********************

	function automatic logic probe(input int sel);
		case (sel)
			SIG_AWVALID: return awvalid;
			SIG_WVALID:  return wvalid;
			SIG_BREADY:  return bready;
			SIG_TIMEOUT: return wr_timeout;
			default:     return alarm_out_n;
		endcase
	endfunction

	// Polls on the falling edge
	task automatic wait_for(input int sel, input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (probe(sel) !== level && n < limit) begin
			@(negedge sys_clk);
			n++;
		end
		if (probe(sel) !== level) begin
			$display("timeout in %s: %s did not reach %b within %0d cycles",
				test_name, what, level, limit);
			timed_out = 1'b1;
		end
	endtask

	// AXI slave for one write, response optional
	task automatic serve_write(input int aw_limit, input int aw_delay, input int w_delay,
			input int b_delay, input bit respond, output int rise_cycle);
		motor_axi_pkg::axi_id_t   id_seen;
		motor_axi_pkg::axi_data_t data_seen;
		rise_cycle = 0;
		wait_for(SIG_AWVALID, 1'b1, aw_limit, "awvalid");
		if (timed_out)
			return;
		rise_cycle = cycle;
		exp_id = exp_id + 1'b1;
		id_seen = awid;
		check_id("awid", exp_id, awid);
		// Motor register sits at address zero
		check_addr("awaddr", 16'h0000, awaddr);
		// Single full-width INCR beat
		check_burst("awlen", 8'd0, awlen);
		check_burst("awsize", 8'd3, {5'b00000, awsize});
		check_burst("awburst", 8'd1, {6'b000000, awburst});
		repeat (aw_delay) begin
			@(negedge sys_clk);
			check_bit("awvalid held", 1'b1, awvalid);
			check_id("awid held", id_seen, awid);
		end
		awready = 1'b1;
		@(negedge sys_clk);
		awready = 1'b0;

		wait_for(SIG_WVALID, 1'b1, PHASE_LIMIT, "wvalid");
		if (timed_out)
			return;
		data_seen = wdata;
		check_data("wdata", motor_word(exp_cmd), wdata);
		check_bit("wstrb all ones", 1'b1, &wstrb);
		check_bit("wlast", 1'b1, wlast);
		repeat (w_delay) begin
			@(negedge sys_clk);
			check_bit("wvalid held", 1'b1, wvalid);
			check_data("wdata held", data_seen, wdata);
		end
		wready = 1'b1;
		@(negedge sys_clk);
		wready = 1'b0;

		wait_for(SIG_BREADY, 1'b1, PHASE_LIMIT, "bready");
		if (timed_out || !respond)
			return;
		repeat (b_delay) begin
			@(negedge sys_clk);
			check_bit("bready held", 1'b1, bready);
		end
		bid    = id_seen;
		bresp  = 2'b00;
		bvalid = 1'b1;
		@(negedge sys_clk);
		bvalid = 1'b0;
		check_bit("bready after response", 1'b0, bready);
		exp_cmd = exp_cmd + 1'b1;
	endtask

	// Serial master, four sys_clk cycles per bit
	task automatic spi_frame(input motor_ctrl_pkg::dac_frame_t tx,
			output motor_ctrl_pkg::dac_frame_t rx);
		rx = '0;
		sync_n = 1'b0;
		@(negedge sys_clk);
		for (int i = FRAME_BITS - 1; i >= 0; i--) begin
			sdin = tx[i];
			sclk = 1'b1;
			repeat (2) @(negedge sys_clk);
			rx[i] = sdo;
			sclk = 1'b0;
			repeat (2) @(negedge sys_clk);
		end
		sync_n = 1'b1;
		sdin   = 1'b0;
		repeat (2) @(negedge sys_clk);
	endtask

	// ********************
	// Tests
	// ********************

	task automatic check_idle_outputs(input string phase);
		check_bit({phase, " awvalid"}, 1'b0, awvalid);
		check_bit({phase, " wvalid"}, 1'b0, wvalid);
		check_bit({phase, " bready"}, 1'b0, bready);
		check_bit({phase, " wr_timeout"}, 1'b0, wr_timeout);
		check_bit({phase, " sdo"}, 1'b0, sdo);
		check_bit({phase, " alarm_out_n"}, 1'b1, alarm_out_n);
		check_id({phase, " awid"}, '0, awid);
	endtask

	task automatic reset_state();
		test_name = "reset_state";
		check_idle_outputs("in reset");
		sys_rst = 1'b0;
		@(negedge sys_clk);
		check_idle_outputs("after reset");
	endtask

	task automatic periodic_write();
		int rise;
		int prev_rise;
		test_name = "periodic_write";
		prev_rise = 0;
		for (int i = 0; i < 3; i++) begin
			serve_write(AW_WAIT_LIMIT, ready_delay(), ready_delay(), ready_delay(), 1'b1, rise);
			if (timed_out)
				return;
			if (i > 0)
				check_count("awvalid period", PERIOD_CYCLES, rise - prev_rise);
			prev_rise = rise;
		end
	endtask

	task automatic backpressure();
		int rise;
		test_name = "backpressure";
		serve_write(AW_WAIT_LIMIT, 20, 20, ready_delay(), 1'b1, rise);
	endtask

	task automatic watchdog_timeout();
		int rise;
		test_name = "watchdog_timeout";
		serve_write(AW_WAIT_LIMIT, ready_delay(), ready_delay(), 0, 1'b0, rise);
		if (timed_out)
			return;
		// No bvalid, the watchdog has to end the write
		wait_for(SIG_TIMEOUT, 1'b1, PHASE_LIMIT, "wr_timeout");
		if (timed_out)
			return;
		check_bit("bready at timeout", 1'b0, bready);
		@(negedge sys_clk);
		check_bit("wr_timeout one cycle", 1'b0, wr_timeout);
		serve_write(AW_WAIT_LIMIT, ready_delay(), ready_delay(), ready_delay(), 1'b1, rise);
	endtask

	task automatic alarm_window();
		int rise;
		test_name = "alarm_window";
		wait_for(SIG_ALARM_N, 1'b0, PERIOD_CYCLES + 100, "alarm_out_n");
		if (timed_out)
			return;
		alarm_reset = 1'b1;
		@(negedge sys_clk);
		alarm_reset = 1'b0;
		check_bit("alarm_out_n after alarm_reset", 1'b1, alarm_out_n);
		@(negedge sys_clk);
		check_bit("alarm_out_n past window", 1'b1, alarm_out_n);
		// Timer now sits past the window, the next trigger is near
		serve_write(300, ready_delay(), ready_delay(), ready_delay(), 1'b1, rise);
	endtask

	task automatic dac_readback();
		motor_ctrl_pkg::dac_frame_t rx;
		test_name = "dac_readback";
		spi_frame(motor_ctrl_pkg::DAC_READ_FRAME, rx);
		check_cmd("sdo in command frame", '0, rx);
		spi_frame('0, rx);
		check_cmd("readback frame", readback_frame(exp_cmd), rx);
		spi_frame('0, rx);
		check_cmd("sdo after readback", '0, rx);
	endtask

	initial begin
		sys_rst     = 1'b1;
		alarm_reset = 1'b0;
		awready     = 1'b0;
		wready      = 1'b0;
		bid         = '0;
		bresp       = 2'b00;
		bvalid      = 1'b0;
		sclk        = 1'b0;
		sync_n      = 1'b1;
		sdin        = 1'b0;
		errors      = 0;
		timed_out   = 1'b0;
		exp_cmd     = motor_ctrl_pkg::CMD_INIT;
		exp_id      = '0;
		test_name   = "setup";
		void'($urandom(32'h61f4c1a0));

		repeat (5) @(negedge sys_clk);
		reset_state();
		if (!timed_out)
			periodic_write();
		if (!timed_out)
			backpressure();
		if (!timed_out)
			watchdog_timeout();
		if (!timed_out)
			alarm_window();
		if (!timed_out)
			dac_readback();

		$display("Errors: %0d failed checks, %0d failed assertions, %0d timeouts",
			errors, DUT.u_props.assert_errors, timed_out);
		if (errors == 0 && DUT.u_props.assert_errors == 0 && !timed_out)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
